// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	typedef logic [15:0] word_t; // one instruction or data word.
	typedef logic [15:0] addr_t; // word address.
	typedef logic [63:0] line_t; // four words, word 0 in the low bits.
	typedef logic [13:0] line_addr_t; // word address without the offset bits.
	typedef logic [7:0] tag_t;
	typedef logic [5:0] index_t;

	localparam int CACHE_SETS = 64;
	localparam int WORDS_PER_LINE = 4;
	localparam int MEM_LATENCY = 4; // accepted request to ready pulse.

	// lookup result of one cache.
	typedef struct packed {
		logic hit;
		logic dirty;
		tag_t tag;
		line_t line;
	} cache_status_t;

	typedef struct packed {
		logic we;
		logic wdirty;
		line_t line;
	} cache_write_t;

	typedef struct packed {
		logic re;
		logic we;
		line_addr_t line_addr;
		line_t wdata;
	} mem_req_t;

	typedef enum logic [1:0] {ST_IDLE, ST_WRITEBACK, ST_ALLOCATE, ST_FILL} ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache (
	input wire logic clk,
	input wire logic i_rst,
	input wire mem_pkg::line_addr_t i_line_addr,
	input wire mem_pkg::cache_write_t i_write,
	output mem_pkg::cache_status_t o_status
);
	import mem_pkg::*;

	tag_t tags [CACHE_SETS];
	line_t lines [CACHE_SETS];
	logic [CACHE_SETS-1:0] valid;
	logic [CACHE_SETS-1:0] dirty;

	tag_t tag;
	index_t index;
	logic entry_valid;

	// split the line address into tag and set index.
	assign index = i_line_addr[$bits(index_t)-1:0];
	assign tag = i_line_addr[$bits(line_addr_t)-1 -: $bits(tag_t)];

	assign entry_valid = valid[index];

	// lookup is purely combinational.
	always_comb begin
		o_status.hit = entry_valid && (tags[index] == tag);
		o_status.dirty = entry_valid && dirty[index]; // only a valid line can be dirty.
		o_status.tag = tags[index];
		o_status.line = lines[index];
	end

	// valid and dirty bits.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_write.we) begin
			valid[index] <= 1'b1;
			dirty[index] <= i_write.wdirty; // fill writes clean, store merge writes dirty.
		end
	end

	// tag and line storage.
	always_ff @(posedge clk) begin
		if (i_write.we) begin
			tags[index] <= tag; // the entry takes the tag of the current address.
			lines[index] <= i_write.line;
		end
	end

endmodule

`default_nettype wire

// ==== logic/unified_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module unified_mem (
	input wire logic clk,
	input wire logic i_rst,
	input wire mem_pkg::mem_req_t i_req,
	output mem_pkg::line_t o_rd_line,
	output logic o_rdy
);
	import mem_pkg::*;

	line_t mem [2**$bits(line_addr_t)];

	mem_req_t pending; // request being served.
	logic busy;
	logic [$clog2(MEM_LATENCY)-1:0] count;
	logic accept;
	logic done;

	// contents start at zero and survive reset.
	initial begin
		for (int i = 0; i < 2**$bits(line_addr_t); i++) begin
			mem[i] = '0;
		end
	end

	assign accept = !busy && (i_req.re || i_req.we); // only taken while idle.
	assign done = busy && (count == 1);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			busy <= 1'b0;
			count <= '0;
			o_rdy <= 1'b0;
		end else begin
			o_rdy <= done; // ready lands MEM_LATENCY cycles after the request.
			if (accept) begin
				busy <= 1'b1;
				count <= $bits(count)'(MEM_LATENCY - 1);
			end else if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				count <= count - 1'b1;
			end
		end
	end

	// latch the request fields when it is accepted.
	always_ff @(posedge clk) begin
		if (accept)
			pending <= i_req;
	end

	// the array access happens in the last busy cycle.
	always_ff @(posedge clk) begin
		if (done) begin
			if (pending.we)
				mem[pending.line_addr] <= pending.wdata;
			else
				o_rd_line <= mem[pending.line_addr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/cache_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_controller (
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_fetch,
	input wire logic i_load,
	input wire logic i_store,
	input wire mem_pkg::addr_t i_fetch_addr,
	input wire mem_pkg::addr_t i_data_addr,
	input wire mem_pkg::word_t i_store_data,
	input wire mem_pkg::cache_status_t i_istat,
	input wire mem_pkg::cache_status_t i_dstat,
	input wire mem_pkg::line_t i_mem_line,
	input wire logic i_mem_rdy,
	output mem_pkg::cache_write_t o_iwrite,
	output mem_pkg::cache_write_t o_dwrite,
	output mem_pkg::mem_req_t o_mem_req,
	output logic o_stall
);
	import mem_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	line_addr_t i_line;
	line_addr_t d_line;
	index_t d_index;
	logic [$clog2(WORDS_PER_LINE)-1:0] d_offset;

	logic i_miss;
	logic d_miss;
	logic wb_start; // dirty data victim goes out first.
	logic rd_start; // line read straight from idle.
	logic store_hit;
	line_t merged;

	logic miss_data; // the miss being served belongs to the data side.
	line_addr_t miss_line;
	logic rd_pending; // read still to issue after a writeback.
	line_t fill_line;

	assign i_line = i_fetch_addr[$bits(addr_t)-1 -: $bits(line_addr_t)];
	assign d_line = i_data_addr[$bits(addr_t)-1 -: $bits(line_addr_t)];
	assign d_index = d_line[$bits(index_t)-1:0];
	assign d_offset = i_data_addr[$clog2(WORDS_PER_LINE)-1:0];

	assign i_miss = i_fetch && !i_istat.hit;
	assign d_miss = (i_load || i_store) && !i_dstat.hit;

	// instruction side always wins when both miss.
	assign wb_start = (state == ST_IDLE) && !i_miss && d_miss && i_dstat.dirty;
	assign rd_start = (state == ST_IDLE) && (i_miss || d_miss) && !wb_start;

	// a store only commits in the cycle where it completes.
	assign store_hit = (state == ST_IDLE) && i_store && i_dstat.hit && !i_miss;

	assign o_stall = (state != ST_IDLE) || i_miss || d_miss;

	// replace the addressed word of the hit line.
	always_comb begin
		merged = i_dstat.line;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			if (d_offset == w)
				merged[w*$bits(word_t) +: $bits(word_t)] = i_store_data;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (wb_start)
					state_next = ST_WRITEBACK;
				else if (rd_start)
					state_next = ST_ALLOCATE;
			end
			ST_WRITEBACK: begin
				if (i_mem_rdy)
					state_next = ST_ALLOCATE;
			end
			ST_ALLOCATE: begin
				if (i_mem_rdy)
					state_next = ST_FILL;
			end
			ST_FILL: state_next = ST_IDLE; // retried access hits next cycle.
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= ST_IDLE;
			miss_data <= 1'b0;
			rd_pending <= 1'b0;
		end else begin
			state <= state_next;
			rd_pending <= (state == ST_WRITEBACK) && i_mem_rdy;
			if (wb_start || rd_start)
				miss_data <= !i_miss;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_start || rd_start)
			miss_line <= i_miss ? i_line : d_line;
		if ((state == ST_ALLOCATE) && i_mem_rdy)
			fill_line <= i_mem_line; // read data is only valid with ready.
	end

	// memory strobes are single cycle.
	always_comb begin
		o_mem_req = '0;
		if (wb_start) begin
			o_mem_req.we = 1'b1;
			o_mem_req.line_addr = {i_dstat.tag, d_index}; // victim address.
			o_mem_req.wdata = i_dstat.line;
		end else if (rd_start) begin
			o_mem_req.re = 1'b1;
			o_mem_req.line_addr = i_miss ? i_line : d_line;
		end else if ((state == ST_ALLOCATE) && rd_pending) begin
			o_mem_req.re = 1'b1;
			o_mem_req.line_addr = miss_line;
		end
	end

	always_comb begin
		o_iwrite.we = (state == ST_FILL) && !miss_data;
		o_iwrite.wdirty = 1'b0; // instruction lines are never dirty.
		o_iwrite.line = fill_line;
	end

	always_comb begin
		o_dwrite.we = 1'b0;
		o_dwrite.wdirty = 1'b0;
		o_dwrite.line = merged;
		if ((state == ST_FILL) && miss_data) begin
			o_dwrite.we = 1'b1;
			o_dwrite.line = fill_line; // refill comes in clean.
		end else if (store_hit) begin
			o_dwrite.we = 1'b1;
			o_dwrite.wdirty = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mem_hierarchy.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hierarchy (
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_fetch,
	input wire logic i_load,
	input wire logic i_store,
	input wire mem_pkg::addr_t i_fetch_addr,
	input wire mem_pkg::addr_t i_data_addr,
	input wire mem_pkg::word_t i_store_data,
	output wire logic o_stall,
	output mem_pkg::word_t o_instr,
	output mem_pkg::word_t o_load_data
);
	import mem_pkg::*;

	line_addr_t i_line_addr;
	line_addr_t d_line_addr;
	logic [$clog2(WORDS_PER_LINE)-1:0] i_offset;
	logic [$clog2(WORDS_PER_LINE)-1:0] d_offset;

	cache_status_t istat;
	cache_status_t dstat;
	cache_write_t iwrite;
	cache_write_t dwrite;
	mem_req_t mem_req;
	line_t mem_line;
	logic mem_rdy;

	// upper address bits pick the line, low bits pick the word.
	assign i_line_addr = i_fetch_addr[$bits(addr_t)-1 -: $bits(line_addr_t)];
	assign d_line_addr = i_data_addr[$bits(addr_t)-1 -: $bits(line_addr_t)];
	assign i_offset = i_fetch_addr[$clog2(WORDS_PER_LINE)-1:0];
	assign d_offset = i_data_addr[$clog2(WORDS_PER_LINE)-1:0];

	cache icache (
		.clk(clk),
		.i_rst(i_rst),
		.i_line_addr(i_line_addr),
		.i_write(iwrite),
		.o_status(istat)
	);

	cache dcache (
		.clk(clk),
		.i_rst(i_rst),
		.i_line_addr(d_line_addr),
		.i_write(dwrite),
		.o_status(dstat)
	);

	unified_mem main_mem (
		.clk(clk),
		.i_rst(i_rst),
		.i_req(mem_req),
		.o_rd_line(mem_line),
		.o_rdy(mem_rdy)
	);

	cache_controller controller (
		.clk(clk),
		.i_rst(i_rst),
		.i_fetch(i_fetch),
		.i_load(i_load),
		.i_store(i_store),
		.i_fetch_addr(i_fetch_addr),
		.i_data_addr(i_data_addr),
		.i_store_data(i_store_data),
		.i_istat(istat),
		.i_dstat(dstat),
		.i_mem_line(mem_line),
		.i_mem_rdy(mem_rdy),
		.o_iwrite(iwrite),
		.o_dwrite(dwrite),
		.o_mem_req(mem_req),
		.o_stall(o_stall)
	);

	// word 0 sits in the low bits of a line.
	assign o_instr = istat.line[i_offset*$bits(word_t) +: $bits(word_t)];
	assign o_load_data = dstat.line[d_offset*$bits(word_t) +: $bits(word_t)]; // valid when stall is low.

endmodule

`default_nettype wire

// ==== tests/mem_hierarchy_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hierarchy_tb;
	import mem_pkg::*;

	localparam int PERIOD = 100;
	localparam int TIMEOUT_CYCLES = 64;
	localparam int RANDOM_OPS = 300;

	logic clk;
	logic i_rst;
	logic i_fetch;
	logic i_load;
	logic i_store;
	addr_t i_fetch_addr;
	addr_t i_data_addr;
	word_t i_store_data;
	logic o_stall;
	word_t o_instr;
	word_t o_load_data;

	word_t shadow [2**15]; // data words below 16'h8000.
	int stall_cycles;
	word_t instr_seen;
	word_t load_seen;
	int checks;
	int errors;
	int tests_passed;
	int tests_failed;
	int test_start_errors;
	bit timed_out;

	mem_hierarchy uut (
		.clk(clk),
		.i_rst(i_rst),
		.i_fetch(i_fetch),
		.i_load(i_load),
		.i_store(i_store),
		.i_fetch_addr(i_fetch_addr),
		.i_data_addr(i_data_addr),
		.i_store_data(i_store_data),
		.o_stall(o_stall),
		.o_instr(o_instr),
		.o_load_data(o_load_data)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic check_word(input string what, input addr_t addr, input word_t got,
			input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t ns: %s at %h returned %h, expected %h",
				$time, what, addr, got, exp);
		end
	endtask

	task automatic check_true(input string what, input bit cond);
		checks++;
		assert (cond) else begin
			errors++;
			$display("** Error at %0t ns: %s", $time, what);
		end
	endtask

	task automatic finish_run();
		$display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// ends the run once an access has timed out.
	initial begin
		wait (timed_out);
		finish_run();
	end

	// called on a falling edge, returns on a falling edge with the request dropped.
	task automatic run_access(input logic fetch, input logic load, input logic store,
			input addr_t faddr, input addr_t daddr, input word_t sdata, output bit ok);
		int cycles;
		i_fetch = fetch;
		i_load = load;
		i_store = store;
		i_fetch_addr = faddr;
		i_data_addr = daddr;
		i_store_data = sdata;
		cycles = 0;
		#(PERIOD / 4); // sample in the low phase, well away from both edges.
		while (o_stall && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			#(PERIOD / 4);
			cycles++;
		end
		stall_cycles = cycles;
		ok = !o_stall;
		if (ok) begin
			instr_seen = o_instr;
			load_seen = o_load_data;
			@(negedge clk); // a store commits on the rising edge in between.
			i_fetch = 1'b0;
			i_load = 1'b0;
			i_store = 1'b0;
		end else begin
			$display("timeout: stall still high after %0d cycles, controller in %s",
				TIMEOUT_CYCLES, uut.controller.state.name());
			errors++;
			timed_out = 1'b1;
			@(negedge clk); // the run ends before this edge.
		end
	endtask

	task automatic fetch_and_check(input addr_t addr);
		bit ok;
		run_access(1'b1, 1'b0, 1'b0, addr, 16'h0000, 16'h0000, ok);
		if (ok)
			check_word("fetch", addr, instr_seen, 16'h0000); // fetch area is never stored to.
	endtask

	task automatic store_word(input addr_t addr, input word_t data);
		bit ok;
		run_access(1'b0, 1'b0, 1'b1, 16'h8000, addr, data, ok);
		if (ok)
			shadow[addr[14:0]] = data;
	endtask

	task automatic load_and_check(input addr_t addr);
		bit ok;
		run_access(1'b0, 1'b1, 1'b0, 16'h8000, addr, 16'h0000, ok);
		if (ok)
			check_word("load", addr, load_seen, shadow[addr[14:0]]);
	endtask

	task automatic fetch_and_load(input addr_t faddr, input addr_t daddr);
		bit ok;
		run_access(1'b1, 1'b1, 1'b0, faddr, daddr, 16'h0000, ok);
		if (ok) begin
			check_word("paired fetch", faddr, instr_seen, 16'h0000);
			check_word("paired load", daddr, load_seen, shadow[daddr[14:0]]);
		end
	endtask

	// four tags compete for each of four sets.
	function automatic addr_t conflict_addr(input bit instr_side);
		addr_t a;
		a = '0;
		a[15] = instr_side;
		a[9:8] = 2'($urandom);
		a[3:2] = 2'($urandom);
		a[1:0] = 2'($urandom);
		return a;
	endfunction

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_start_errors);
		end
	endtask

	initial begin
		int op;
		for (int i = 0; i < 2**15; i++) begin
			shadow[i] = '0;
		end
		void'($urandom(32'h1727));
		checks = 0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		i_rst = 1'b1;
		i_fetch = 1'b0;
		i_load = 1'b0;
		i_store = 1'b0;
		i_fetch_addr = '0;
		i_data_addr = '0;
		i_store_data = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		i_rst = 1'b0;

		begin_test();
		#(PERIOD / 4);
		check_true("stall high while idle after reset", !o_stall);
		@(negedge clk);
		fetch_and_check(16'h8000);
		check_true("cold fetch did not stall", stall_cycles >= 1);
		fetch_and_check(16'h8003);
		check_true("repeat fetch in the same line stalled", stall_cycles == 0);
		end_test("reset and cold fetch");

		begin_test();
		store_word(16'h0041, 16'hbeef);
		for (int w = 0; w < 4; w++) begin
			load_and_check(16'h0040 + 16'(w));
			check_true("load hit stalled", stall_cycles == 0);
		end
		end_test("store then load hit");

		begin_test();
		store_word(16'h0010, 16'h1234);
		store_word(16'h0110, 16'h5678); // same set, different tag.
		load_and_check(16'h0010);
		load_and_check(16'h0110);
		end_test("dirty eviction");

		begin_test();
		store_word(16'h0230, 16'h3abc);
		store_word(16'h0330, 16'h4def); // leaves a dirty victim in the set of 16'h0230.
		fetch_and_load(16'h9230, 16'h0230);
		fetch_and_load(16'h9231, 16'h0231);
		end_test("simultaneous access");

		begin_test();
		for (int n = 0; n < RANDOM_OPS; n++) begin
			op = $urandom % 4;
			case (op)
				0: fetch_and_check(conflict_addr(1'b1));
				1: load_and_check(conflict_addr(1'b0));
				2: store_word(conflict_addr(1'b0), 16'($urandom));
				default: fetch_and_load(conflict_addr(1'b1), conflict_addr(1'b0));
			endcase
		end
		end_test("random traffic");

		finish_run();
	end

endmodule

`default_nettype wire

// ==== mem_hierarchy.f ====
logic/mem_pkg.sv
logic/cache.sv
logic/unified_mem.sv
logic/cache_controller.sv
logic/mem_hierarchy.sv
tests/mem_hierarchy_tb.sv

// ==== Makefile ====
TOP := mem_hierarchy_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mem_hierarchy.f logic/*.sv tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		-f mem_hierarchy.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns \
		-f mem_hierarchy.f --top-module mem_hierarchy

clean:
	rm -rf obj_dir
